// ==== logic/cmd_decode.sv ====
// one finished frame is held until taken and any byte that arrives while it waits is dropped and flags ovr_o
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            rx_valid_i,
    input  ctrl_pkg::byte_t rx_data_i,
    input  logic            cmd_take_i,
    output logic            cmd_valid_o,
    output ctrl_pkg::cmd_t  cmd_o,
    output logic            ovr_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_HOLD
    } state_t;

    state_t         state_q;
    state_t         first_state;
    ctrl_pkg::cmd_t cmd_q;
    logic           ovr_q;
    logic           op_load;

    // a byte in the take cycle already opens the next frame
    assign op_load = rx_valid_i &&
                     ((state_q == S_IDLE) || ((state_q == S_HOLD) && cmd_take_i));

    always_comb begin
        case (rx_data_i)
            ctrl_pkg::OP_WR,
            ctrl_pkg::OP_RD:  first_state = S_ADDR;
            ctrl_pkg::OP_SPI: first_state = S_DATA;
            default:          first_state = S_HOLD;  // unknown opcode is a one-byte frame
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            ovr_q   <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (op_load) begin
                        state_q <= first_state;
                    end
                end
                S_ADDR: begin
                    if (rx_valid_i) begin
                        state_q <= (cmd_q.op == ctrl_pkg::OP_WR) ? S_DATA : S_HOLD;
                    end
                end
                S_DATA: begin
                    if (rx_valid_i) begin
                        state_q <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    if (op_load) begin
                        state_q <= first_state;
                    end else if (cmd_take_i) begin
                        state_q <= S_IDLE;
                    end else if (rx_valid_i) begin
                        ovr_q <= 1'b1;  // sticky until reset
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_load) begin
            cmd_q.op <= rx_data_i;
        end
        if (rx_valid_i && (state_q == S_ADDR)) begin
            cmd_q.addr <= rx_data_i;
        end
        if (rx_valid_i && (state_q == S_DATA)) begin
            cmd_q.data <= rx_data_i;
        end
    end

    assign cmd_valid_o = (state_q == S_HOLD);
    assign cmd_o       = cmd_q;
    assign ovr_o       = ovr_q;

endmodule

`default_nettype wire

// ==== logic/cmd_execute.sv ====
// REG_COUNT may be 1 to 256 and the bank index uses only the low address bits once the range check passes
`timescale 1ns/1ps
`default_nettype none

module cmd_execute #(
    parameter int REG_COUNT   = 8,
    parameter int SPI_CLK_DIV = 4
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              cmd_valid_i,
    input  ctrl_pkg::cmd_t    cmd_i,
    input  logic              rsp_busy_i,
    input  logic              miso_i,
    output logic              cmd_take_o,
    output logic              res_valid_o,
    output ctrl_pkg::result_t res_o,
    output logic              spi_clk_o,
    output logic              spi_mosi_o,
    output logic              spi_cs_o
);

    localparam int AW = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SPI,
        S_HOLD
    } state_t;

    state_t            state_q;
    ctrl_pkg::byte_t   regs_q [REG_COUNT];
    ctrl_pkg::result_t res_q;
    ctrl_pkg::result_t imm_res;
    ctrl_pkg::byte_t   tx_q;
    ctrl_pkg::byte_t   rx_byte;
    logic [AW-1:0]     idx;
    logic              addr_ok;
    logic              is_spi;
    logic              can_take;
    logic              wr_en;
    logic              spi_start_q;
    logic              spi_done;

    assign idx     = cmd_i.addr[AW-1:0];
    assign addr_ok = ({1'b0, cmd_i.addr} < 9'(REG_COUNT));
    assign is_spi  = (cmd_i.op == ctrl_pkg::OP_SPI);

    // the pulses still high mean the frame or its result is one cycle old
    assign can_take = (state_q == S_IDLE) && cmd_valid_i && !cmd_take_o && !res_valid_o &&
                      (is_spi || !rsp_busy_i);
    assign wr_en    = can_take && (cmd_i.op == ctrl_pkg::OP_WR) && addr_ok;

    always_comb begin
        case (cmd_i.op)
            ctrl_pkg::OP_WR: begin
                imm_res = addr_ok ? '{status: ctrl_pkg::ST_OK, data: cmd_i.data}
                                  : '{status: ctrl_pkg::ST_ERR_ADDR, data: cmd_i.addr};
            end
            ctrl_pkg::OP_RD: begin
                imm_res = addr_ok ? '{status: ctrl_pkg::ST_OK, data: regs_q[idx]}
                                  : '{status: ctrl_pkg::ST_ERR_ADDR, data: cmd_i.addr};
            end
            default: imm_res = '{status: ctrl_pkg::ST_ERR_OP, data: cmd_i.op};
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[idx] <= cmd_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= S_IDLE;
            cmd_take_o  <= 1'b0;
            res_valid_o <= 1'b0;
            spi_start_q <= 1'b0;
        end else begin
            cmd_take_o  <= 1'b0;
            res_valid_o <= 1'b0;
            spi_start_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (can_take) begin
                        cmd_take_o <= 1'b1;
                        if (is_spi) begin
                            spi_start_q <= 1'b1;
                            state_q     <= S_SPI;
                        end else begin
                            res_valid_o <= 1'b1;
                        end
                    end
                end
                S_SPI: begin
                    if (spi_done) begin
                        res_valid_o <= !rsp_busy_i;
                        state_q     <= rsp_busy_i ? S_HOLD : S_IDLE;
                    end
                end
                S_HOLD: begin
                    if (!rsp_busy_i) begin
                        res_valid_o <= 1'b1;
                        state_q     <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (can_take) begin
            res_q <= imm_res;
            tx_q  <= cmd_i.data;
        end else if ((state_q == S_SPI) && spi_done) begin
            res_q <= '{status: ctrl_pkg::ST_OK, data: rx_byte};
        end
    end

    assign res_o = res_q;

    spi_byte_master #(
        .SPI_CLK_DIV(SPI_CLK_DIV)
    ) i_spi_byte_master (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (spi_start_q),
        .tx_byte_i (tx_q),
        .miso_i    (miso_i),
        .done_o    (spi_done),
        .rx_byte_o (rx_byte),
        .spi_clk_o (spi_clk_o),
        .spi_mosi_o(spi_mosi_o),
        .spi_cs_o  (spi_cs_o)
    );

endmodule

`default_nettype wire

// ==== logic/ctrl_pkg.sv ====
// every field is one byte wide and any opcode other than OP_WR, OP_RD or OP_SPI is answered with ST_ERR_OP
`default_nettype none

package ctrl_pkg;

    typedef logic [7:0] byte_t;  // data, address, opcode and status all share this width

    typedef struct packed {
        byte_t op;
        byte_t addr;
        byte_t data;
    } cmd_t;

    typedef struct packed {
        byte_t status;
        byte_t data;
    } result_t;

    // frame is opcode, address, data
    localparam byte_t OP_WR  = 8'h01;
    // frame is opcode, address
    localparam byte_t OP_RD  = 8'h02;
    // frame is opcode, data
    localparam byte_t OP_SPI = 8'h03;

    localparam byte_t ST_OK       = 8'h00;
    localparam byte_t ST_ERR_OP   = 8'hEE;  // the data byte carries the rejected opcode
    localparam byte_t ST_ERR_ADDR = 8'hEA;  // the data byte carries the rejected address

endpackage

`default_nettype wire

// ==== logic/ctrl_top.sv ====
// synchronous active-low reset and rx bytes must be spaced so that decode never holds an untaken frame
`timescale 1ns/1ps
`default_nettype none

module ctrl_top #(
    parameter int REG_COUNT   = 8,
    parameter int SPI_CLK_DIV = 4
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            rx_valid_i,
    input  ctrl_pkg::byte_t rx_data_i,
    input  logic            spi_miso_i,
    output logic            rsp_valid_o,
    output ctrl_pkg::byte_t rsp_data_o,
    output logic            ovr_o,
    output logic            spi_clk_o,
    output logic            spi_mosi_o,
    output logic            spi_cs_o
);

    logic              cmd_valid;
    ctrl_pkg::cmd_t    cmd;
    logic              cmd_take;
    logic              res_valid;
    ctrl_pkg::result_t res;
    logic              rsp_busy;

    cmd_decode i_cmd_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rx_valid_i (rx_valid_i),
        .rx_data_i  (rx_data_i),
        .cmd_take_i (cmd_take),
        .cmd_valid_o(cmd_valid),
        .cmd_o      (cmd),
        .ovr_o      (ovr_o)
    );

    cmd_execute #(
        .REG_COUNT  (REG_COUNT),
        .SPI_CLK_DIV(SPI_CLK_DIV)
    ) i_cmd_execute (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .cmd_valid_i(cmd_valid),
        .cmd_i      (cmd),
        .rsp_busy_i (rsp_busy),
        .miso_i     (spi_miso_i),
        .cmd_take_o (cmd_take),
        .res_valid_o(res_valid),
        .res_o      (res),
        .spi_clk_o  (spi_clk_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_cs_o   (spi_cs_o)
    );

    rsp_result i_rsp_result (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .res_valid_i(res_valid),
        .res_i      (res),
        .rsp_busy_o (rsp_busy),
        .rsp_valid_o(rsp_valid_o),
        .rsp_data_o (rsp_data_o)
    );

endmodule

`default_nettype wire

// ==== logic/rsp_result.sv ====
// a result is accepted only while rsp_busy_o is low and goes out as status then data on back-to-back cycles
`timescale 1ns/1ps
`default_nettype none

module rsp_result (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              res_valid_i,
    input  ctrl_pkg::result_t res_i,
    output logic              rsp_busy_o,
    output logic              rsp_valid_o,
    output ctrl_pkg::byte_t   rsp_data_o
);

    typedef enum logic {
        S_IDLE,
        S_DATA
    } state_t;

    state_t          state_q;
    ctrl_pkg::byte_t data_q;
    logic            valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (res_valid_i) begin
                        state_q <= S_DATA;
                        valid_q <= 1'b1;
                    end
                end
                S_DATA: begin
                    state_q <= S_IDLE;
                    valid_q <= 1'b1;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == S_IDLE) && res_valid_i) begin
            data_q     <= res_i.data;
            rsp_data_o <= res_i.status;
        end else if (state_q == S_DATA) begin
            rsp_data_o <= data_q;
        end
    end

    // covers the status cycle and the data cycle that follows it
    assign rsp_busy_o  = valid_q;
    assign rsp_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== logic/spi_byte_master.sv ====
// mode 0 only, MSB first, one active-low select and SPI_CLK_DIV clock cycles per SCLK half-period
`timescale 1ns/1ps
`default_nettype none

module spi_byte_master #(
    parameter int SPI_CLK_DIV = 4
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  ctrl_pkg::byte_t tx_byte_i,
    input  logic            miso_i,
    output logic            done_o,
    output ctrl_pkg::byte_t rx_byte_o,
    output logic            spi_clk_o,
    output logic            spi_mosi_o,
    output logic            spi_cs_o
);

    localparam int DW = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;

    typedef enum logic {
        S_IDLE,
        S_SHIFT
    } state_t;

    state_t          state_q;
    logic [DW-1:0]   div_q;
    logic [2:0]      bit_q;
    ctrl_pkg::byte_t tx_q;
    ctrl_pkg::byte_t rx_q;
    logic            sclk_q;
    logic            cs_q;
    logic            done_q;
    logic            half_tick;

    assign half_tick = (div_q == DW'(SPI_CLK_DIV - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            div_q   <= '0;
            bit_q   <= '0;
            tx_q    <= '0;
            sclk_q  <= 1'b0;
            cs_q    <= 1'b1;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_SHIFT;
                        cs_q    <= 1'b0;
                        tx_q    <= tx_byte_i;  // first bit is on mosi a half-period before the rising edge
                        div_q   <= '0;
                        bit_q   <= '0;
                    end
                end
                S_SHIFT: begin
                    if (half_tick) begin
                        div_q  <= '0;
                        sclk_q <= ~sclk_q;
                        if (sclk_q) begin
                            if (bit_q == 3'd7) begin
                                state_q <= S_IDLE;
                                cs_q    <= 1'b1;  // sclk is already back low here
                                done_q  <= 1'b1;
                            end else begin
                                bit_q <= bit_q + 3'd1;
                                tx_q  <= {tx_q[6:0], 1'b0};
                            end
                        end
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == S_SHIFT) && half_tick && !sclk_q) begin
            rx_q <= {rx_q[6:0], miso_i};  // sampled on the rising sclk edge
        end
    end

    assign done_o     = done_q;
    assign rx_byte_o  = rx_q;
    assign spi_clk_o  = sclk_q;
    assign spi_mosi_o = tx_q[7];
    assign spi_cs_o   = cs_q;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status follows the pass line.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module ctrl_tb --Mdir obj_dir -f src.f; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vctrl_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== src.f ====
logic/ctrl_pkg.sv
logic/spi_byte_master.sv
logic/cmd_decode.sv
logic/cmd_execute.sv
logic/rsp_result.sv
logic/ctrl_top.sv
verification/ctrl_asserts.sv
verification/ctrl_tb.sv

// ==== verification/ctrl_asserts.sv ====
// bound into every ctrl_top and assumes response strobes always come in status and data pairs
`timescale 1ns/1ps
`default_nettype none

module ctrl_asserts (
    input logic clk_i,
    input logic rst_n_i,
    input logic rsp_valid_i,
    input logic spi_clk_i,
    input logic spi_cs_i
);

    logic data_due;  // the next strobe carries the data byte

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_due <= 1'b0;
        end else if (rsp_valid_i) begin
            data_due <= !data_due;
        end
    end

    status_then_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i && !data_due |=> rsp_valid_i)
        else $error("status byte was not followed by a data byte");

    sclk_idle_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        spi_cs_i |-> !spi_clk_i)
        else $error("spi clock high while chip select is inactive");

    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !rsp_valid_i)
        else $error("response strobe during reset");

endmodule

bind ctrl_top ctrl_asserts u_ctrl_asserts (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rsp_valid_i(rsp_valid_o),
    .spi_clk_i  (spi_clk_o),
    .spi_cs_i   (spi_cs_o)
);

`default_nettype wire

// ==== verification/ctrl_tb.sv ====
// assumes REG_COUNT 8 and an SPI loopback from mosi to miso, so every SPI transfer echoes its byte
`timescale 1ns/1ps
`default_nettype none

module ctrl_tb;

    localparam int REG_COUNT      = 8;
    localparam int SPI_CLK_DIV    = 4;
    localparam int NUM_TESTS      = 6;
    localparam int TEST_BUDGET_NS = 20000;  // time allowed for each test
    localparam int RSP_TIMEOUT    = 1000;   // clock cycles to wait for one response

    logic            clk;
    logic            rst_n;
    logic            rx_valid;
    ctrl_pkg::byte_t rx_data;
    logic            rsp_valid;
    ctrl_pkg::byte_t rsp_data;
    logic            ovr;
    logic            spi_clk;
    logic            spi_mosi;
    logic            spi_cs;

    ctrl_pkg::byte_t rsp_q[$];
    ctrl_pkg::byte_t model_regs[REG_COUNT];  // expected register contents
    int              seed = 78124;
    int              sclk_rises = 0;
    logic            sclk_prev = 1'b0;
    logic            cs_high_on_rise = 1'b0;

    ctrl_top #(
        .REG_COUNT  (REG_COUNT),
        .SPI_CLK_DIV(SPI_CLK_DIV)
    ) dut0 (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .rx_valid_i (rx_valid),
        .rx_data_i  (rx_data),
        .spi_miso_i (spi_mosi),  // loopback
        .rsp_valid_o(rsp_valid),
        .rsp_data_o (rsp_data),
        .ovr_o      (ovr),
        .spi_clk_o  (spi_clk),
        .spi_mosi_o (spi_mosi),
        .spi_cs_o   (spi_cs)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // sclk edges are counted on the falling clk edge where all outputs are settled
    always @(negedge clk) begin
        if (spi_clk && !sclk_prev) begin
            sclk_rises = sclk_rises + 1;
            if (spi_cs) cs_high_on_rise = 1'b1;
        end
        sclk_prev = spi_clk;
    end

    task automatic stop_with_error();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic collect_responses();
        forever begin
            @(negedge clk);
            if (rst_n && rsp_valid) rsp_q.push_back(rsp_data);
        end
    endtask

    initial collect_responses();

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic check_byte(input string name, input ctrl_pkg::byte_t got,
                              input ctrl_pkg::byte_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic check_result(input string name, input ctrl_pkg::result_t got,
                                input ctrl_pkg::result_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            stop_with_error();
        end
    endtask

    function automatic ctrl_pkg::result_t make_result(input ctrl_pkg::byte_t status,
                                                      input ctrl_pkg::byte_t data);
        ctrl_pkg::result_t r;
        r.status = status;
        r.data   = data;
        return r;
    endfunction

    function automatic ctrl_pkg::byte_t rand_byte();
        return ctrl_pkg::byte_t'($random(seed));
    endfunction

    // one cycle of strobe, then one idle cycle so the next frame meets the take cycle
    task automatic send_byte(input ctrl_pkg::byte_t b);
        rx_valid = 1'b1;
        rx_data  = b;
        @(posedge clk);
        #2;
        rx_valid = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic send_cmd(input ctrl_pkg::byte_t op, input ctrl_pkg::byte_t addr,
                            input ctrl_pkg::byte_t data);
        send_byte(op);
        if (op == ctrl_pkg::OP_WR || op == ctrl_pkg::OP_RD) send_byte(addr);
        if (op == ctrl_pkg::OP_WR || op == ctrl_pkg::OP_SPI) send_byte(data);
    endtask

    task automatic expect_result(input string name, input ctrl_pkg::result_t exp);
        ctrl_pkg::result_t got;
        int                waited;
        waited = 0;
        while (rsp_q.size() < 2) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > RSP_TIMEOUT) begin
                $display("no response arrived for %s", name);
                stop_with_error();
            end
        end
        got.status = rsp_q.pop_front();
        got.data   = rsp_q.pop_front();
        check_result(name, got, exp);
    endtask

    task automatic read_all_regs(input string name);
        for (int a = 0; a < REG_COUNT; a++) begin
            send_cmd(ctrl_pkg::OP_RD, ctrl_pkg::byte_t'(a), 8'h00);
            expect_result(name, make_result(ctrl_pkg::ST_OK, model_regs[a]));
        end
    endtask

    task automatic test_reset();
        check_bit("rsp_valid_o", rsp_valid, 1'b0);
        check_bit("ovr_o", ovr, 1'b0);
        check_bit("spi_clk_o", spi_clk, 1'b0);
        check_bit("spi_cs_o", spi_cs, 1'b1);
        for (int a = 0; a < REG_COUNT; a++) model_regs[a] = 8'h00;
        read_all_regs("read after reset");
    endtask

    task automatic test_write_read();
        ctrl_pkg::byte_t val;
        for (int a = 0; a < REG_COUNT; a++) begin
            val = rand_byte();
            send_cmd(ctrl_pkg::OP_WR, ctrl_pkg::byte_t'(a), val);
            expect_result("write response", make_result(ctrl_pkg::ST_OK, val));
            model_regs[a] = val;
        end
        read_all_regs("read back");
    endtask

    task automatic test_spi();
        ctrl_pkg::byte_t val;
        val             = rand_byte();
        sclk_rises      = 0;
        cs_high_on_rise = 1'b0;
        send_cmd(ctrl_pkg::OP_SPI, 8'h00, val);
        expect_result("spi loopback", make_result(ctrl_pkg::ST_OK, val));
        if (sclk_rises != 8) begin
            $display("spi_clk_o gave %0d rising edges instead of 8", sclk_rises);
            stop_with_error();
        end
        if (cs_high_on_rise) begin
            $display("spi_cs_o was high at a rising edge of spi_clk_o");
            stop_with_error();
        end
    endtask

    task automatic test_errors();
        send_cmd(8'h7F, 8'h00, 8'h00);
        expect_result("unknown opcode", make_result(ctrl_pkg::ST_ERR_OP, 8'h7F));
        send_cmd(ctrl_pkg::OP_WR, 8'h08, rand_byte());
        expect_result("write out of range", make_result(ctrl_pkg::ST_ERR_ADDR, 8'h08));
        send_cmd(ctrl_pkg::OP_RD, 8'h08, 8'h00);
        expect_result("read out of range", make_result(ctrl_pkg::ST_ERR_ADDR, 8'h08));
        read_all_regs("read after errors");
    endtask

    task automatic test_pipeline();
        ctrl_pkg::byte_t addr;
        ctrl_pkg::byte_t val;
        addr = ctrl_pkg::byte_t'(rand_byte() % REG_COUNT);
        val  = rand_byte();
        send_cmd(ctrl_pkg::OP_WR, addr, val);
        send_cmd(ctrl_pkg::OP_RD, addr, 8'h00);
        model_regs[addr] = val;
        expect_result("pipelined write", make_result(ctrl_pkg::ST_OK, val));
        expect_result("pipelined read", make_result(ctrl_pkg::ST_OK, val));
        check_bit("ovr_o", ovr, 1'b0);
    endtask

    task automatic test_overrun();
        ctrl_pkg::byte_t addr;
        ctrl_pkg::byte_t val;
        addr = ctrl_pkg::byte_t'(rand_byte() % REG_COUNT);
        val  = rand_byte();
        send_cmd(ctrl_pkg::OP_SPI, 8'h00, val);
        send_cmd(ctrl_pkg::OP_RD, addr, 8'h00);
        if (spi_cs) begin
            $display("the SPI transfer ended before the extra byte could be sent");
            stop_with_error();
        end
        send_byte(8'h55);  // decode still holds the read frame
        check_bit("ovr_o", ovr, 1'b1);
        expect_result("spi during overrun", make_result(ctrl_pkg::ST_OK, val));
        expect_result("read during overrun", make_result(ctrl_pkg::ST_OK, model_regs[addr]));
        repeat (6) @(posedge clk);  // an accepted extra byte would have answered by now
        check_byte("queued response bytes", ctrl_pkg::byte_t'(rsp_q.size()), 8'h00);
    endtask

    initial begin
        #(NUM_TESTS * TEST_BUDGET_NS);
        $display("watchdog expired before the tests completed");
        stop_with_error();
    end

    initial begin
        rst_n    = 1'b0;
        rx_valid = 1'b0;
        rx_data  = 8'h00;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_write_read();
        test_spi();
        test_errors();
        test_pipeline();
        test_overrun();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
